// File: logic/lsu_pkg.sv
// Shared widths, operation codes, exception causes and structs of the load/store unit
`default_nettype none

package lsu_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned BE_W       = XLEN / 8;
  localparam int unsigned TRANS_ID_W = 3;

  // Bit 3 marks a store, bit 2 zero extension, bits 1:0 the size
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } lsu_op_e;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } lsu_size_e;

  // Standard mcause encodings
  typedef enum logic [3:0] {
    EXC_NONE        = 4'd0,
    EXC_LD_MISALIGN = 4'd4,
    EXC_LD_ACCESS   = 4'd5,
    EXC_ST_MISALIGN = 4'd6,
    EXC_ST_ACCESS   = 4'd7
  } exc_cause_e;

  typedef struct packed {
    lsu_op_e               op;
    logic [XLEN-1:0]       base;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       wdata;
    logic [TRANS_ID_W-1:0] trans_id;
  } lsu_req_t;

  typedef struct packed {
    lsu_op_e               op;
    logic [XLEN-1:0]       addr;
    logic [BE_W-1:0]       be;
    logic [XLEN-1:0]       wdata;
    logic [TRANS_ID_W-1:0] trans_id;
    logic                  misaligned;
    exc_cause_e            cause;
  } mem_req_t;

  typedef struct packed {
    lsu_op_e               op;
    logic [1:0]            addr_lo;
    logic [XLEN-1:0]       rdata;
    logic                  err;
    logic [XLEN-1:0]       addr;
    logic [TRANS_ID_W-1:0] trans_id;
  } mem_rsp_t;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } lsu_exc_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       data;
    lsu_exc_t              exc;
  } lsu_result_t;

  // ------------------------------
  // Decode helpers
  // ------------------------------
  function automatic logic is_store_op(lsu_op_e op);
    return op[3];
  endfunction

  function automatic lsu_size_e size_of_op(lsu_op_e op);
    return lsu_size_e'(op[1:0]);
  endfunction

  function automatic logic [BE_W-1:0] be_of(lsu_size_e size, logic [1:0] addr_lo);
    case (size)
      SIZE_B:  return BE_W'(4'b0001) << addr_lo;
      SIZE_H:  return BE_W'(4'b0011) << addr_lo;
      default: return {BE_W{1'b1}};
    endcase
  endfunction

  // Halfwords need bit 0 clear, words both low bits clear
  function automatic logic misaligned_of(lsu_op_e op, logic [1:0] addr_lo);
    case (size_of_op(op))
      SIZE_H:  return addr_lo[0];
      SIZE_W:  return |addr_lo;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: logic/lsu_issue.sv
// Issue stage of the load/store unit; forms address, byte enables and holds one request
`default_nettype none

module lsu_issue
  import lsu_pkg::*;
#(
  parameter int unsigned ADDR_W = 12
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // Issue side
  input  wire logic     req_valid_i,
  input  wire lsu_req_t req_i,
  output logic          req_ready_o,
  // Release from the result stage
  input  wire logic     done_i,
  // Toward the APB master
  output logic          mreq_valid_o,
  output mem_req_t      mreq_o
);

  // Keeps ADDR_W bits of the sum, also for ADDR_W equal to XLEN
  localparam logic [XLEN-1:0] ADDR_MASK = {XLEN{1'b1}} >> (XLEN - ADDR_W);

  logic            accept;
  logic            busy_q;
  logic            strobe_q;
  logic [XLEN-1:0] addr_sum;
  logic [XLEN-1:0] addr;
  lsu_size_e       size;
  mem_req_t        req_d;
  mem_req_t        req_q;

  // ------------------------------
  // Address generation
  // ------------------------------
  assign addr_sum = req_i.base + req_i.imm;
  assign addr     = addr_sum & ADDR_MASK;
  assign size     = size_of_op(req_i.op);

  // Byte enables, lane shift and misalignment
  always_comb begin
    req_d            = '0;
    req_d.op         = req_i.op;
    req_d.addr       = addr;
    req_d.be         = be_of(size, addr[1:0]);
    req_d.wdata      = req_i.wdata << {addr[1:0], 3'b000};
    req_d.trans_id   = req_i.trans_id;
    req_d.misaligned = misaligned_of(req_i.op, addr[1:0]);
    if (req_d.misaligned) begin
      req_d.cause = is_store_op(req_i.op) ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    end else begin
      req_d.cause = EXC_NONE;
    end
  end

  // ------------------------------
  // Request register
  // ------------------------------
  assign accept = req_valid_i & ~busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Payload only, qualified by busy_q
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_d;
    end
  end

  // One request in flight, so ready is simply not busy
  assign req_ready_o  = ~busy_q;
  assign mreq_valid_o = strobe_q;
  assign mreq_o       = req_q;

  // Result stage only releases a request that is actually held
  a_done_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |-> busy_q
  );

endmodule

`default_nettype wire

// File: logic/lsu_apb_master.sv
// APB master of the load/store unit; runs one transfer per request or bypasses misaligned ones
`default_nettype none

module lsu_apb_master
  import lsu_pkg::*;
#(
  parameter int unsigned ADDR_W = 12
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // Request from the issue stage, held stable until done
  input  wire logic              mreq_valid_i,
  input  wire mem_req_t          mreq_i,
  // APB
  output logic [ADDR_W-1:0]      paddr_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [XLEN-1:0]        pwdata_o,
  output logic [BE_W-1:0]        pstrb_o,
  input  wire logic [XLEN-1:0]   prdata_i,
  input  wire logic              pready_i,
  input  wire logic              pslverr_i,
  // Response toward the result stage
  output logic                   rsp_valid_o,
  output mem_rsp_t               rsp_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   bypass_q;
  logic   xfer_done;

  // ------------------------------
  // Transfer FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (mreq_valid_i && !mreq_i.misaligned) begin
          state_d = SETUP;
        end
      end
      SETUP:  state_d = ACCESS;
      ACCESS: begin
        if (pready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      bypass_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      // Misaligned requests never reach the bus
      bypass_q <= mreq_valid_i & mreq_i.misaligned;
    end
  end

  assign xfer_done = (state_q == ACCESS) && pready_i;

  // ------------------------------
  // APB outputs
  // ------------------------------
  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);
  assign paddr_o   = {mreq_i.addr[ADDR_W-1:2], 2'b00};
  assign pwrite_o  = is_store_op(mreq_i.op);
  assign pwdata_o  = mreq_i.wdata;
  assign pstrb_o   = pwrite_o ? mreq_i.be : '0;

  // Response on the completion edge, or one cycle after a bypassed request
  assign rsp_valid_o    = xfer_done | bypass_q;
  assign rsp_o.op       = mreq_i.op;
  assign rsp_o.addr_lo  = mreq_i.addr[1:0];
  assign rsp_o.rdata    = xfer_done ? prdata_i : '0;
  assign rsp_o.err      = xfer_done & pslverr_i;
  assign rsp_o.addr     = mreq_i.addr;
  assign rsp_o.trans_id = mreq_i.trans_id;

  // Request register upstream must hold through SETUP and wait states
  a_stable_xfer: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    psel_o && !xfer_done |=>
      $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o) && $stable(pstrb_o)
  );

endmodule

`default_nettype wire

// File: logic/lsu_result.sv
// Result stage of the load/store unit; extends load data, forms exceptions, drives results
`default_nettype none

module lsu_result
  import lsu_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     rsp_valid_i,
  input  wire mem_rsp_t rsp_i,
  output lsu_result_t   load_o,
  output lsu_result_t   store_o,
  output logic          done_o
);

  logic            is_store;
  logic            misaligned;
  logic            sign_ext;
  logic [XLEN-1:0] lane;
  logic [XLEN-1:0] ext_data;
  lsu_result_t     res_d;
  lsu_result_t     res_q;
  logic            ld_valid_q;
  logic            st_valid_q;

  assign is_store   = is_store_op(rsp_i.op);
  assign misaligned = misaligned_of(rsp_i.op, rsp_i.addr_lo);
  // Bit 2 of the op selects zero extension
  assign sign_ext   = ~rsp_i.op[2];

  // ------------------------------
  // Load data extraction
  // ------------------------------
  assign lane = rsp_i.rdata >> {rsp_i.addr_lo, 3'b000};

  always_comb begin
    case (size_of_op(rsp_i.op))
      SIZE_B:  ext_data = {{(XLEN-8){sign_ext & lane[7]}}, lane[7:0]};
      SIZE_H:  ext_data = {{(XLEN-16){sign_ext & lane[15]}}, lane[15:0]};
      default: ext_data = lane;
    endcase
  end

  // Exception forming, misaligned wins over access fault
  always_comb begin
    res_d           = '0;
    res_d.valid     = 1'b1;
    res_d.trans_id  = rsp_i.trans_id;
    res_d.exc.valid = misaligned | rsp_i.err;
    if (misaligned) begin
      res_d.exc.cause = is_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    end else if (rsp_i.err) begin
      res_d.exc.cause = is_store ? EXC_ST_ACCESS : EXC_LD_ACCESS;
    end
    res_d.exc.tval = res_d.exc.valid ? rsp_i.addr : '0;
    res_d.data     = (is_store || res_d.exc.valid) ? '0 : ext_data;
  end

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_valid_q <= 1'b0;
      st_valid_q <= 1'b0;
    end else begin
      ld_valid_q <= rsp_valid_i & ~is_store;
      st_valid_q <= rsp_valid_i & is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      res_q <= res_d;
    end
  end

  // Both ports share one payload register
  always_comb begin
    load_o        = res_q;
    load_o.valid  = ld_valid_q;
    store_o       = res_q;
    store_o.valid = st_valid_q;
  end

  assign done_o = ld_valid_q | st_valid_q;

  // Each result is a single-cycle pulse
  a_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o
  );

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
// Top level of the load/store unit; instantiate with ADDR_W matching the APB data memory
`default_nettype none

module lsu_top
  import lsu_pkg::*;
#(
  parameter int unsigned ADDR_W = 12
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  // Issue side
  input  wire logic            req_valid_i,
  input  wire lsu_req_t        req_i,
  output logic                 req_ready_o,
  // APB master
  output logic [ADDR_W-1:0]    paddr_o,
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output logic [XLEN-1:0]      pwdata_o,
  output logic [BE_W-1:0]      pstrb_o,
  input  wire logic [XLEN-1:0] prdata_i,
  input  wire logic            pready_i,
  input  wire logic            pslverr_i,
  // Results
  output lsu_result_t          load_o,
  output lsu_result_t          store_o
);

  logic     mreq_valid;
  mem_req_t mreq;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     done;

  lsu_issue #(
    .ADDR_W (ADDR_W)
  ) i_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .done_i       (done),
    .mreq_valid_o (mreq_valid),
    .mreq_o       (mreq)
  );

  lsu_apb_master #(
    .ADDR_W (ADDR_W)
  ) i_apb_master (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mreq_valid_i (mreq_valid),
    .mreq_i       (mreq),
    .paddr_o      (paddr_o),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .pwrite_o     (pwrite_o),
    .pwdata_o     (pwdata_o),
    .pstrb_o      (pstrb_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp)
  );

  lsu_result i_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .load_o      (load_o),
    .store_o     (store_o),
    .done_o      (done)
  );

endmodule

`default_nettype wire

// File: verif/apb_mem_model.sv
// APB slave memory for the LSU testbench; random wait states, PSLVERR at and above 0x800
`default_nettype none

module apb_mem_model #(
  parameter int unsigned ADDR_W = 12,
  parameter logic [31:0] SEED   = 32'h9577ebe1
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic [ADDR_W-1:0] paddr_i,
  input  wire logic              psel_i,
  input  wire logic              penable_i,
  input  wire logic              pwrite_i,
  input  wire logic [31:0]       pwdata_i,
  input  wire logic [3:0]        pstrb_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [ADDR_W-1:0] ERR_BASE = ADDR_W'(32'h800);

  logic [31:0] mem [0:511];
  logic [1:0]  wait_q;
  logic        err;
  logic [31:0] rnd;
  integer      seed;

  // Same pattern as the testbench reference memory
  function automatic logic [31:0] fill_word(input logic [31:0] idx);
    return (idx * 32'h9e3779b1) ^ 32'h5a5a5a5a;
  endfunction

  initial begin
    seed = SEED;
    for (int i = 0; i < 512; i++) begin
      mem[i] = fill_word(32'(i));
    end
  end

  assign err       = paddr_i >= ERR_BASE;
  assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
  assign pslverr_o = pready_o && err;
  assign prdata_o  = (pready_o && !err && !pwrite_i) ? mem[paddr_i[10:2]] : 32'h0;

  // Wait states drawn in SETUP, counted down in ACCESS
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= 2'd0;
    end else if (psel_i && !penable_i) begin
      rnd = $random(seed);
      wait_q <= rnd[1:0];
    end else if (psel_i && penable_i && wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  always @(posedge clk_i) begin
    if (pready_o && pwrite_i && !err) begin
      for (int b = 0; b < 4; b++) begin
        if (pstrb_i[b]) begin
          mem[paddr_i[10:2]][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_lsu.sv
// Testbench for lsu_top; predicts each result from a reference memory and checks by assertions
`default_nettype none

module tb_lsu
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned     ADDR_W       = 12;
  localparam int unsigned     NUM_REQ      = 300;
  localparam int unsigned     NUM_DIRECTED = 30;
  localparam int unsigned     RESET_CYCLES = 8;
  // At most 8 cycles per request with 3 wait states, plus reset
  localparam int unsigned     MAX_CYCLES   = NUM_REQ * 8 + 8 * RESET_CYCLES;
  localparam logic [31:0]     SEED         = 32'h9577ebe1;
  localparam logic [XLEN-1:0] ADDR_MASK    = (32'd1 << ADDR_W) - 32'd1;
  localparam logic [XLEN-1:0] ERR_BASE     = 32'h800;

  typedef struct packed {
    logic              store;
    logic              misaligned;
    logic [BE_W-1:0]   strb;
    logic [ADDR_W-1:0] paddr;
    logic [XLEN-1:0]   wdata;
    lsu_result_t       res;
  } expect_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  req_valid;
  lsu_req_t              req_in;
  logic                  req_ready;
  logic [ADDR_W-1:0]     paddr;
  logic                  psel;
  logic                  psel_q;
  logic                  penable;
  logic                  pwrite;
  logic [XLEN-1:0]       pwdata;
  logic [BE_W-1:0]       pstrb;
  logic [XLEN-1:0]       prdata;
  logic                  pready;
  logic                  pslverr;
  lsu_result_t           load_res;
  lsu_result_t           store_res;
  expect_t               exp_q;
  logic                  in_flight;
  logic [TRANS_ID_W-1:0] next_id;
  logic [XLEN-1:0]       ref_mem [0:511];
  lsu_op_e               st_ops [3];
  lsu_op_e               ld_ops [5];
  integer                seed;
  int unsigned           cycle_cnt = 0;

  always #4 clk_i = ~clk_i;

  lsu_top #(
    .ADDR_W (ADDR_W)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid),
    .req_i       (req_in),
    .req_ready_o (req_ready),
    .paddr_o     (paddr),
    .psel_o      (psel),
    .penable_o   (penable),
    .pwrite_o    (pwrite),
    .pwdata_o    (pwdata),
    .pstrb_o     (pstrb),
    .prdata_i    (prdata),
    .pready_i    (pready),
    .pslverr_i   (pslverr),
    .load_o      (load_res),
    .store_o     (store_res)
  );

  apb_mem_model #(
    .ADDR_W (ADDR_W),
    .SEED   (SEED)
  ) i_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  // ------------------------------
  // Failure handling and checks
  // ------------------------------
  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // Set on acceptance, cleared by the result pulse
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight <= 1'b0;
    end else if (req_valid && req_ready) begin
      in_flight <= 1'b1;
    end else if (load_res.valid || store_res.valid) begin
      in_flight <= 1'b0;
    end
  end

  // Select of the previous cycle tells ACCESS from SETUP
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      psel_q <= 1'b0;
    end else begin
      psel_q <= psel;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, requests did not complete", cycle_cnt);
      abort_run();
    end
  end

  // Enable is low in SETUP and high through ACCESS, never without select
  a_penable: assert property (
    @(posedge clk_i) disable iff (!rst_ni) penable == (psel && psel_q)
  ) else begin
      $display("[FAIL] %0t ns penable_o expected %b got %b", $time,
               $sampled(psel) && $sampled(psel_q), $sampled(penable));
      abort_run();
    end

  a_paddr: assert property (@(posedge clk_i) disable iff (!rst_ni) psel |-> paddr == exp_q.paddr)
    else begin
      $display("[FAIL] %0t ns paddr_o expected %h got %h", $time, exp_q.paddr, paddr);
      abort_run();
    end

  a_pwrite: assert property (@(posedge clk_i) disable iff (!rst_ni) psel |-> pwrite == exp_q.store)
    else begin
      $display("[FAIL] %0t ns pwrite_o expected %b got %b", $time, exp_q.store, pwrite);
      abort_run();
    end

  // Read strobes are zero, so this also covers pstrb_o on reads
  a_pstrb: assert property (@(posedge clk_i) disable iff (!rst_ni) psel |-> pstrb == exp_q.strb)
    else begin
      $display("[FAIL] %0t ns pstrb_o expected %h got %h", $time, exp_q.strb, pstrb);
      abort_run();
    end

  a_pwdata: assert property (
    @(posedge clk_i) disable iff (!rst_ni) psel && exp_q.store |-> pwdata == exp_q.wdata
  ) else begin
      $display("[FAIL] %0t ns pwdata_o expected %h got %h", $time, exp_q.wdata, pwdata);
      abort_run();
    end

  a_no_bus_misaligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni) in_flight && exp_q.misaligned |-> !psel
  ) else begin
      $display("[FAIL] %0t ns psel_o expected 0 got 1 on a misaligned access", $time);
      abort_run();
    end

  a_ready_low: assert property (@(posedge clk_i) disable iff (!rst_ni) in_flight |-> !req_ready)
    else begin
      $display("[FAIL] %0t ns req_ready_o expected 0 got 1 while busy", $time);
      abort_run();
    end

  a_one_result: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (load_res.valid || store_res.valid) |-> in_flight
  ) else begin
      $display("[FAIL] %0t ns result valid without an open request", $time);
      abort_run();
    end

  // ------------------------------
  // Reference model and stimulus
  // ------------------------------
  function automatic logic [31:0] fill_word(input logic [31:0] idx);
    return (idx * 32'h9e3779b1) ^ 32'h5a5a5a5a;
  endfunction

  task automatic predict(input lsu_req_t req, output expect_t e);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] lane;
    lsu_size_e       size;
    logic            bad_align;
    addr      = (req.base + req.imm) & ADDR_MASK;
    size      = size_of_op(req.op);
    bad_align = (size == SIZE_H && addr[0]) || (size == SIZE_W && addr[1:0] != 2'b00);
    e              = '0;
    e.store        = (req.op == SB) || (req.op == SH) || (req.op == SW);
    e.misaligned   = bad_align;
    e.paddr        = {addr[ADDR_W-1:2], 2'b00};
    e.strb         = e.store ? be_of(size, addr[1:0]) : '0;
    e.wdata        = req.wdata << {addr[1:0], 3'b000};
    e.res.valid    = 1'b1;
    e.res.trans_id = req.trans_id;
    word           = ref_mem[addr[10:2]];
    if (bad_align) begin
      e.res.exc.valid = 1'b1;
      e.res.exc.cause = e.store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
      e.res.exc.tval  = addr;
    end else if (addr >= ERR_BASE) begin
      e.res.exc.valid = 1'b1;
      e.res.exc.cause = e.store ? EXC_ST_ACCESS : EXC_LD_ACCESS;
      e.res.exc.tval  = addr;
    end else if (e.store) begin
      for (int b = 0; b < 4; b++) begin
        if (e.strb[b]) begin
          word[8*b +: 8] = e.wdata[8*b +: 8];
        end
      end
      ref_mem[addr[10:2]] = word;
    end else begin
      lane = word >> {addr[1:0], 3'b000};
      case (req.op)
        LB:      e.res.data = {{24{lane[7]}}, lane[7:0]};
        LBU:     e.res.data = {24'h0, lane[7:0]};
        LH:      e.res.data = {{16{lane[15]}}, lane[15:0]};
        LHU:     e.res.data = {16'h0, lane[15:0]};
        default: e.res.data = lane;
      endcase
    end
  endtask

  // Drive one request, wait for its result and compare it
  task automatic send(input lsu_req_t req);
    expect_t     e;
    lsu_result_t got;
    string       port;
    req.trans_id = next_id;
    next_id      = next_id + 1'b1;
    predict(req, e);
    while (!req_ready) begin
      @(posedge clk_i);
      #1;
    end
    exp_q     = e;
    req_in    = req;
    req_valid = 1'b1;
    @(posedge clk_i);
    #1;
    req_valid = 1'b0;
    while (!(load_res.valid || store_res.valid)) begin
      @(posedge clk_i);
      #1;
    end
    check_field("store_o.valid", 32'(e.store), 32'(store_res.valid));
    check_field("load_o.valid", 32'(!e.store), 32'(load_res.valid));
    got  = e.store ? store_res : load_res;
    port = e.store ? "store_o" : "load_o";
    check_field({port, ".trans_id"}, 32'(e.res.trans_id), 32'(got.trans_id));
    check_field({port, ".data"}, e.res.data, got.data);
    check_field({port, ".exc.valid"}, 32'(e.res.exc.valid), 32'(got.exc.valid));
    check_field({port, ".exc.cause"}, 32'(e.res.exc.cause), 32'(got.exc.cause));
    check_field({port, ".exc.tval"}, e.res.exc.tval, got.exc.tval);
  endtask

  // Mostly a small window so loads hit earlier stores, sometimes the error window
  task automatic random_req(output lsu_req_t r);
    logic [31:0] rnd;
    rnd = $random(seed);
    case (rnd[2:0])
      3'd0:    r.op = LB;
      3'd1:    r.op = LBU;
      3'd2:    r.op = LH;
      3'd3:    r.op = LHU;
      3'd4:    r.op = LW;
      3'd5:    r.op = SB;
      3'd6:    r.op = SH;
      default: r.op = SW;
    endcase
    if (rnd[5:3] == 3'd0) begin
      r.base = 32'h800 + {24'h0, rnd[9:6], 4'h0};
    end else begin
      r.base = 32'h100 + {26'h0, rnd[7:6], 4'h0};
    end
    r.imm = {{27{rnd[14]}}, rnd[14:10]};
    if (rnd[16]) begin
      r.imm[1:0] = 2'b00;
    end
    r.wdata    = $random(seed);
    r.trans_id = '0;
  endtask

  initial begin
    lsu_req_t   req;
    logic [1:0] st_off;
    logic [1:0] ld_off;
    int         k;
    seed      = SEED;
    rst_ni    = 1'b0;
    req_valid = 1'b0;
    req_in    = '0;
    exp_q     = '0;
    next_id   = '0;
    st_ops    = '{SB, SH, SW};
    ld_ops    = '{LB, LBU, LH, LHU, LW};
    for (int i = 0; i < 512; i++) begin
      ref_mem[i] = fill_word(32'(i));
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_field("psel_o", 32'd0, 32'(psel));
    check_field("load_o.valid", 32'd0, 32'(load_res.valid));
    check_field("store_o.valid", 32'd0, 32'(store_res.valid));
    check_field("req_ready_o", 32'd1, 32'(req_ready));

    // Each store size followed by each load size over the same bytes
    for (int s = 0; s < 3; s++) begin
      for (int l = 0; l < 5; l++) begin
        k = s * 5 + l;
        case (st_ops[s])
          SB:      st_off = k[1:0];
          SH:      st_off = {k[0], 1'b0};
          default: st_off = 2'b00;
        endcase
        case (size_of_op(ld_ops[l]))
          SIZE_B:  ld_off = st_off;
          SIZE_H:  ld_off = {st_off[1], 1'b0};
          default: ld_off = 2'b00;
        endcase
        req.op       = st_ops[s];
        req.base     = 32'h200 + 32'(k * 16);
        req.imm      = {30'h0, st_off};
        req.wdata    = $random(seed);
        req.trans_id = '0;
        send(req);
        req.op  = ld_ops[l];
        req.imm = {30'h0, ld_off};
        send(req);
      end
    end

    for (int n = 0; n < NUM_REQ - NUM_DIRECTED; n++) begin
      random_req(req);
      send(req);
    end

    repeat (2) @(posedge clk_i);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/lsu_pkg.sv
logic/lsu_issue.sv
logic/lsu_apb_master.sv
logic/lsu_result.sv
logic/lsu_top.sv
verif/apb_mem_model.sv
verif/tb_lsu.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv verif/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vtb_lsu: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module tb_lsu -o Vtb_lsu

run: obj_dir/Vtb_lsu
	./obj_dir/Vtb_lsu

lint:
	verilator --lint-only logic/lsu_pkg.sv logic/lsu_issue.sv logic/lsu_apb_master.sv \
		logic/lsu_result.sv logic/lsu_top.sv --top-module lsu_top

clean:
	rm -rf obj_dir
